// File: front_cases.txt
# M word_index data | C pc rs_eq_rt | F pc (flush) | R pc epc (eret) | T test name
# E test pc inst bd ex exccode, in output order
T 1 reset_seq
T 2 branches
T 3 flush
T 4 eret
T 5 adel
M 000 24010001
M 001 24020002
M 002 24030003
M 003 0bf00010
M 004 24040004
M 005 24ff00ff
M 010 24050005
M 011 10000006
M 012 24060006
M 018 24070007
M 019 14000006
M 01a 24080008
M 01b 24090009
M 01c 14000007
M 01d 240a000a
M 024 1000ffdb
M 025 240b000b
M 026 0ff00028
M 027 240c000c
M 028 240d000d
M 029 240e000e
M 02a 240f000f
M 02b 24100010
M 080 24150015
M 081 24160016
M 082 24170017
M 083 24180018
M 0e0 24110011
M 0e1 24120012
M 0e2 24130013
M 0e3 24140014
M 0e4 24190019
M 0e5 241a001a
M 0e6 241b001b
C bfc00044 1
C bfc00064 1
C bfc00070 0
C bfc00090 0
F bfc000a4
R bfc00384 bfc00200
R bfc00204 bfc00302
F bfc00302
E 1 bfc00000 24010001 0 0 1f
E 1 bfc00004 24020002 0 0 1f
E 1 bfc00008 24030003 0 0 1f
E 2 bfc0000c 0bf00010 0 0 1f
E 2 bfc00010 24040004 1 0 1f
E 2 bfc00040 24050005 0 0 1f
E 2 bfc00044 10000006 0 0 1f
E 2 bfc00048 24060006 1 0 1f
E 2 bfc00060 24070007 0 0 1f
E 2 bfc00064 14000006 0 0 1f
E 2 bfc00068 24080008 1 0 1f
E 2 bfc0006c 24090009 0 0 1f
E 2 bfc00070 14000007 0 0 1f
E 2 bfc00074 240a000a 1 0 1f
E 2 bfc00090 1000ffdb 0 0 1f
E 2 bfc00094 240b000b 1 0 1f
E 2 bfc00098 0ff00028 0 0 1f
E 2 bfc0009c 240c000c 1 0 1f
E 2 bfc000a0 240d000d 0 0 1f
E 3 bfc000a4 240e000e 0 0 1f
E 3 bfc00380 24110011 0 0 1f
E 3 bfc00384 24120012 0 0 1f
E 4 bfc00200 24150015 0 0 1f
E 4 bfc00204 24160016 0 0 1f
E 5 bfc00302 24180018 0 1 04
E 5 bfc00380 24110011 0 0 1f
E 5 bfc00384 24120012 0 0 1f
E 5 bfc00388 24130013 0 0 1f
E 5 bfc0038c 24140014 0 0 1f

// File: list.f
cpu_pkg.sv
fs_ds_if.sv
fetch_stage.sv
inst_ram.sv
decode_stage.sv
cpu_front_top.sv
front_sva.sv
tb_front.sv

// File: Bender.yml
package:
  name: cpu_front

sources:
  - cpu_pkg.sv
  - fs_ds_if.sv
  - fetch_stage.sv
  - inst_ram.sv
  - decode_stage.sv
  - cpu_front_top.sv
  - target: test
    files:
      - front_sva.sv
      - tb_front.sv

// File: tb_front.sv
`timescale 1ns/1ps

module tb_front;

    localparam int MAX_REC = 256;  // per record kind

    logic                clk;
    logic                reset;
    logic                es_valid;
    cpu_pkg::word_t      es_pc;
    cpu_pkg::word_t      es_inst;
    logic                es_bd;
    logic                es_ex;
    cpu_pkg::exc_code_t  es_exccode;
    logic                es_allowin;
    logic                rs_eq_rt;
    logic                flush;
    logic                ws_inst_eret;
    cpu_pkg::word_t      cp0_epc;
    logic                imem_we;
    cpu_pkg::imem_addr_t imem_waddr;
    cpu_pkg::word_t      imem_wdata;

    // program image
    cpu_pkg::imem_addr_t mem_idx  [MAX_REC];
    cpu_pkg::word_t      mem_data [MAX_REC];
    // branch compare levels, keyed by the pc in decode
    cpu_pkg::word_t      cmp_pc   [MAX_REC];
    logic                cmp_lvl  [MAX_REC];
    // flush and eret events, used in file order
    cpu_pkg::word_t      ev_pc    [MAX_REC];
    cpu_pkg::word_t      ev_epc   [MAX_REC];
    logic                ev_eret  [MAX_REC];
    // expected output stream
    int                  exp_test [MAX_REC];
    cpu_pkg::word_t      exp_pc   [MAX_REC];
    cpu_pkg::word_t      exp_inst [MAX_REC];
    logic                exp_bd   [MAX_REC];
    logic                exp_ex   [MAX_REC];
    cpu_pkg::exc_code_t  exp_code [MAX_REC];
    reg [8*24-1:0]       test_name [16];

    int     n_mem;
    int     n_cmp;
    int     n_ev;
    int     n_exp;
    integer seed;
    int     errors;
    int     checked;     // records consumed so far
    int     cycles;
    int     limit;       // timeout in cycles
    int     test_base;   // error count when the current test began
    int     ev_next;
    logic   timed_out;
    logic   fire_flush;
    logic   fire_eret;

    cpu_front_top dut (
        .clk          (clk),
        .reset        (reset),
        .es_valid     (es_valid),
        .es_pc        (es_pc),
        .es_inst      (es_inst),
        .es_bd        (es_bd),
        .es_ex        (es_ex),
        .es_exccode   (es_exccode),
        .es_allowin   (es_allowin),
        .rs_eq_rt     (rs_eq_rt),
        .flush        (flush),
        .ws_inst_eret (ws_inst_eret),
        .cp0_epc      (cp0_epc),
        .imem_we      (imem_we),
        .imem_waddr   (imem_waddr),
        .imem_wdata   (imem_wdata)
    );

    bind cpu_front_top front_sva u_sva (
        .clk          (clk),
        .reset        (reset),
        .es_valid     (es_valid),
        .es_allowin   (es_allowin),
        .flush        (flush),
        .ws_inst_eret (ws_inst_eret),
        .es_pc        (es_pc),
        .es_inst      (es_inst),
        .es_bd        (es_bd),
        .es_ex        (es_ex),
        .es_exccode   (es_exccode),
        .inst_en      (inst_en),
        .inst_addr    (inst_addr)
    );

    always #5 clk = ~clk;  // 10 ns period

    task automatic load_cases();
        int             fd;
        int             code;
        logic [31:0]    v0, v1, v2, v3, v4, v5;
        reg [8*16-1:0]  tag;
        reg [8*24-1:0]  name;
        reg [8*128-1:0] rest;
        fd = $fopen("front_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open front_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) break;
            if (tag == "#") begin
                code = $fgets(rest, fd);  // rest of a comment line
            end else if (tag == "T") begin
                code = $fscanf(fd, "%d %s", v0, name);
                test_name[v0] = name;
            end else if (tag == "M") begin
                code = $fscanf(fd, "%h %h", v0, v1);
                mem_idx[n_mem]  = v0[cpu_pkg::IMEM_AW-1:0];
                mem_data[n_mem] = v1;
                n_mem++;
            end else if (tag == "C") begin
                code = $fscanf(fd, "%h %d", v0, v1);
                cmp_pc[n_cmp]  = v0;
                cmp_lvl[n_cmp] = v1[0];
                n_cmp++;
            end else if (tag == "F" || tag == "R") begin
                if (tag == "R") code = $fscanf(fd, "%h %h", v0, v1);
                else code = $fscanf(fd, "%h", v0);
                ev_pc[n_ev]   = v0;
                ev_epc[n_ev]  = (tag == "R") ? v1 : 32'h0;
                ev_eret[n_ev] = (tag == "R");
                n_ev++;
            end else if (tag == "E") begin
                code = $fscanf(fd, "%d %h %h %d %d %h", v0, v1, v2, v3, v4, v5);
                exp_test[n_exp] = v0;
                exp_pc[n_exp]   = v1;
                exp_inst[n_exp] = v2;
                exp_bd[n_exp]   = v3[0];
                exp_ex[n_exp]   = v4[0];
                exp_code[n_exp] = v5[4:0];
                n_exp++;
            end else begin
                $display("unknown record kind in front_cases.txt");
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // rs_eq_rt for the instruction now in decode, low if not listed
    function automatic logic level_for(cpu_pkg::word_t pc);
        logic lvl;
        lvl = 1'b0;
        for (int i = 0; i < n_cmp; i++) begin
            if (cmp_pc[i] == pc) lvl = cmp_lvl[i];
        end
        return lvl;
    endfunction

    task automatic compare_field(string name, logic [31:0] expected, logic [31:0] got);
        if (expected !== got) begin
            $display("Fail %0s expected 0x%0h got 0x%0h", name, expected, got);
            errors++;
        end
    endtask

    task automatic report_test(int t);
        if (errors == test_base) begin
            $display("test %0d %0s: pass", t, test_name[t]);
        end else begin
            $display("test %0d %0s: %0d errors", t, test_name[t], errors - test_base);
        end
        test_base = errors;
    endtask

    task automatic check_item();
        int i;
        i = checked;
        compare_field("es_pc", exp_pc[i], es_pc);
        compare_field("es_inst", exp_inst[i], es_inst);
        compare_field("es_bd", {31'b0, exp_bd[i]}, {31'b0, es_bd});
        compare_field("es_ex", {31'b0, exp_ex[i]}, {31'b0, es_ex});
        compare_field("es_exccode", {27'b0, exp_code[i]}, {27'b0, es_exccode});
        checked++;
        if (checked == n_exp || exp_test[checked] != exp_test[i]) report_test(exp_test[i]);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        es_allowin   = 1'b0;
        rs_eq_rt     = 1'b0;
        flush        = 1'b0;
        ws_inst_eret = 1'b0;
        cp0_epc      = '0;
        imem_we      = 1'b0;
        imem_waddr   = '0;
        imem_wdata   = '0;
        seed         = 7;
        errors       = 0;
        checked      = 0;
        cycles       = 0;
        ev_next      = 0;
        n_mem        = 0;
        n_cmp        = 0;
        n_ev         = 0;
        n_exp        = 0;
        timed_out    = 1'b0;
        fire_flush   = 1'b0;
        fire_eret    = 1'b0;

        load_cases();
        test_base = errors;
        limit     = 20 * n_exp + 100;

        @(posedge clk);
        #1;
        for (int i = 0; i < n_mem; i++) begin  // preload while in reset
            imem_we    = 1'b1;
            imem_waddr = mem_idx[i];
            imem_wdata = mem_data[i];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset      = 1'b0;
        es_allowin = ($random(seed) & 3) != 0;

        while (checked < n_exp && !timed_out) begin
            @(posedge clk);
            cycles++;
            fire_flush = 1'b0;
            fire_eret  = 1'b0;
            // items leaving on a redirect edge are squashed downstream
            if (es_valid && es_allowin && !flush && !ws_inst_eret) begin
                if (ev_next < n_ev && es_pc == ev_pc[ev_next]) begin
                    fire_eret  = ev_eret[ev_next];
                    fire_flush = !ev_eret[ev_next];
                    ev_next++;
                end
                check_item();
            end
            if (cycles >= limit) timed_out = 1'b1;
            #1;
            flush        = fire_flush;  // one cycle strobes
            ws_inst_eret = fire_eret;
            cp0_epc      = fire_eret ? ev_epc[ev_next-1] : 32'h0;
            es_allowin   = ($random(seed) & 3) != 0;  // high about 3 of 4 cycles
            rs_eq_rt     = es_valid ? level_for(es_pc) : 1'b0;
        end

        if (timed_out) begin
            $display("timeout after %0d cycles, output stream stopped early", cycles);
        end
        if (dut.u_sva.fail_count != 0) begin
            $display("%0d assertion failures in the bound checker", dut.u_sva.fail_count);
        end
        errors = errors + dut.u_sva.fail_count;
        $display("checked %0d of %0d records, %0d errors", checked, n_exp, errors);
        if (errors == 0 && !timed_out && n_exp > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: front_sva.sv
`timescale 1ns/1ps

module front_sva (
    input logic               clk,
    input logic               reset,
    input logic               es_valid,
    input logic               es_allowin,
    input logic               flush,
    input logic               ws_inst_eret,
    input cpu_pkg::word_t     es_pc,
    input cpu_pkg::word_t     es_inst,
    input logic               es_bd,
    input logic               es_ex,
    input cpu_pkg::exc_code_t es_exccode,
    input logic               inst_en,
    input cpu_pkg::word_t     inst_addr
);

    int fail_count = 0;  // failed assertions so far

    // decode empties on reset
    a_reset_empty: assert property (@(posedge clk) reset |=> !es_valid)
        else begin
            $error("es_valid high after reset");
            fail_count++;
        end

    // flushed item never reaches execute
    a_flush_empty: assert property (@(posedge clk) disable iff (reset)
        flush |=> !es_valid)
        else begin
            $error("es_valid high after flush");
            fail_count++;
        end

    // held item does not change under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (es_valid && !es_allowin && !flush && !ws_inst_eret)
        |=> (es_valid && $stable(es_pc) && $stable(es_inst) && $stable(es_bd)
             && $stable(es_ex) && $stable(es_exccode)))
        else begin
            $error("es_ outputs changed while held");
            fail_count++;
        end

    // no ram access on a misaligned fetch
    a_no_misaligned_read: assert property (@(posedge clk) disable iff (reset)
        inst_en |-> (inst_addr[1:0] == 2'b00))
        else begin
            $error("inst_en high with misaligned inst_addr");
            fail_count++;
        end

endmodule

// File: cpu_front_top.sv
`timescale 1ns/1ps

module cpu_front_top (
    input  logic                clk,
    input  logic                reset,
    // to execute
    output logic                es_valid,
    output cpu_pkg::word_t      es_pc,
    output cpu_pkg::word_t      es_inst,
    output logic                es_bd,
    output logic                es_ex,
    output cpu_pkg::exc_code_t  es_exccode,
    input  logic                es_allowin,
    // from later stages
    input  logic                rs_eq_rt,      // branch compare result
    input  logic                flush,         // exception taken in writeback
    input  logic                ws_inst_eret,
    input  cpu_pkg::word_t      cp0_epc,
    // program preload
    input  logic                imem_we,
    input  cpu_pkg::imem_addr_t imem_waddr,
    input  cpu_pkg::word_t      imem_wdata
);

    fs_ds_if fs_ds ();  // fetch to decode bundle

    logic           br_taken;
    logic           ds_is_branch;
    cpu_pkg::word_t br_target;
    logic           inst_en;
    cpu_pkg::word_t inst_addr;
    cpu_pkg::word_t inst_rdata;

    fetch_stage u_fetch (
        .clk          (clk),
        .reset        (reset),
        .fs           (fs_ds.fetch),
        .br_taken     (br_taken),
        .ds_is_branch (ds_is_branch),
        .br_target    (br_target),
        .flush        (flush),
        .ws_inst_eret (ws_inst_eret),
        .cp0_epc      (cp0_epc),
        .inst_en      (inst_en),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata)
    );

    decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .fs           (fs_ds.decode),
        .es_allowin   (es_allowin),
        .rs_eq_rt     (rs_eq_rt),
        .flush        (flush),
        .ws_inst_eret (ws_inst_eret),
        .br_taken     (br_taken),
        .ds_is_branch (ds_is_branch),
        .br_target    (br_target),
        .es_valid     (es_valid),
        .es_pc        (es_pc),
        .es_inst      (es_inst),
        .es_bd        (es_bd),
        .es_ex        (es_ex),
        .es_exccode   (es_exccode)
    );

    inst_ram u_imem (
        .clk   (clk),
        .en    (inst_en),
        .addr  (inst_addr),
        .rdata (inst_rdata),
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata)
    );

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    fs_ds_if.decode            fs,
    input  logic               es_allowin,
    input  logic               rs_eq_rt,
    input  logic               flush,
    input  logic               ws_inst_eret,
    output logic               br_taken,
    output logic               ds_is_branch,
    output cpu_pkg::word_t     br_target,
    output logic               es_valid,
    output cpu_pkg::word_t     es_pc,
    output cpu_pkg::word_t     es_inst,
    output logic               es_bd,
    output logic               es_ex,
    output cpu_pkg::exc_code_t es_exccode
);

    // decode register
    logic               ds_valid;
    cpu_pkg::word_t     ds_pc;
    cpu_pkg::word_t     ds_inst;
    logic               ds_bd;
    logic               ds_ex;
    cpu_pkg::exc_code_t ds_exccode;

    logic               ds_allowin;
    logic               ds_kill;     // flush or eret this cycle
    logic               ds_ok;       // live item without exception

    // branch decode
    cpu_pkg::op_t       op;
    cpu_pkg::op_t       funct;
    logic               inst_j;
    logic               inst_jal;
    logic               inst_beq;
    logic               inst_bne;
    logic               inst_jr;
    cpu_pkg::word_t     pc_plus4;
    cpu_pkg::word_t     j_target;    // region jump
    cpu_pkg::word_t     b_offset;    // sign-extended, word scaled
    cpu_pkg::word_t     b_target;

    assign ds_kill    = flush || ws_inst_eret;
    assign ds_allowin = !ds_valid || es_allowin;  // empty or draining
    assign fs.allowin = ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_kill) begin
            ds_valid <= 1'b0;                     // drop whatever is held
        end else if (ds_allowin) begin
            ds_valid <= fs.valid;
        end
    end

    // payload only, loads on an accepted item
    always_ff @(posedge clk) begin
        if (fs.valid && ds_allowin && !ds_kill) begin
            ds_pc      <= fs.pc;
            ds_inst    <= fs.inst;
            ds_bd      <= fs.bd;
            ds_ex      <= fs.ex;
            ds_exccode <= fs.exccode;
        end
    end

    assign op    = ds_inst[31:26];
    assign funct = ds_inst[5:0];

    assign inst_j   = (op == cpu_pkg::OP_J);
    assign inst_jal = (op == cpu_pkg::OP_JAL);
    assign inst_beq = (op == cpu_pkg::OP_BEQ);
    assign inst_bne = (op == cpu_pkg::OP_BNE);
    assign inst_jr  = (op == cpu_pkg::OP_SPECIAL) && (funct == cpu_pkg::FUNCT_JR);

    assign ds_ok = ds_valid && !ds_ex;  // faulted words never branch

    assign pc_plus4 = ds_pc + 32'd4;
    assign j_target = {pc_plus4[31:28], ds_inst[25:0], 2'b00};
    assign b_offset = {{14{ds_inst[15]}}, ds_inst[15:0], 2'b00};
    assign b_target = pc_plus4 + b_offset;

    // jr still opens a delay slot, target needs a register file
    assign ds_is_branch = ds_ok && (inst_j || inst_jal || inst_beq || inst_bne || inst_jr);

    // held while the branch waits here, redirect happens once
    // on the edge the slot moves in and the branch moves out
    assign br_taken = ds_ok && (inst_j || inst_jal
                                || (inst_beq && rs_eq_rt)
                                || (inst_bne && !rs_eq_rt));

    assign br_target = (inst_j || inst_jal) ? j_target : b_target;

    assign es_valid   = ds_valid;
    assign es_pc      = ds_pc;
    assign es_inst    = ds_inst;
    assign es_bd      = ds_bd;
    assign es_ex      = ds_ex;
    assign es_exccode = ds_exccode;

endmodule

// File: inst_ram.sv
`timescale 1ns/1ps

module inst_ram (
    input  logic               clk,
    input  logic               en,
    input  cpu_pkg::word_t     addr,
    output cpu_pkg::word_t     rdata,
    input  logic               we,
    input  cpu_pkg::imem_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t     mem [cpu_pkg::IMEM_DEPTH];  // program image
    cpu_pkg::imem_addr_t raddr;                     // word index of the fetch

    // byte address to word index, upper bits alias
    // so 0xbfc00000 and 0xbfc00380 share one small image
    assign raddr = addr[cpu_pkg::IMEM_AW+1:2];

    // preload port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, holds the last word while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    fs_ds_if.fetch         fs,
    input  logic           br_taken,
    input  logic           ds_is_branch,
    input  cpu_pkg::word_t br_target,
    input  logic           flush,
    input  logic           ws_inst_eret,
    input  cpu_pkg::word_t cp0_epc,
    output logic           inst_en,
    output cpu_pkg::word_t inst_addr,
    input  cpu_pkg::word_t inst_rdata
);

    cpu_pkg::word_t pc;          // address of the word now in fetch
    cpu_pkg::word_t seq_pc;      // fall-through address
    cpu_pkg::word_t next_pc;     // address fetched this cycle
    logic           fs_valid;
    logic           fs_allowin;  // pc may advance on this edge
    logic           adel;        // misaligned fetch address

    // redirects never wait for decode
    assign fs_allowin = (flush || ws_inst_eret) ? 1'b1 : fs.allowin;

    assign seq_pc = pc + 32'd4;

    // eret, then exception, then branch, then sequential
    always_comb begin
        if (ws_inst_eret) begin
            next_pc = cp0_epc;              // return from handler
        end else if (flush) begin
            next_pc = cpu_pkg::EXC_VECTOR;  // enter handler
        end else if (br_taken) begin
            next_pc = br_target;            // branch in decode, slot in fetch
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
            pc       <= cpu_pkg::PC_BEFORE_RESET;  // next_pc reads RESET_PC in reset
        end else begin
            fs_valid <= 1'b1;                      // fetch always has a word after reset
            if (fs_allowin) begin
                pc <= next_pc;
            end
        end
    end

    // ram is addressed with next_pc so rdata lines up with pc
    assign inst_en   = !reset && fs_allowin && (next_pc[1:0] == 2'b00);
    assign inst_addr = next_pc;

    // address error follows the pc register, not next_pc
    assign adel = (pc[1:0] != 2'b00);

    assign fs.valid   = fs_valid;
    assign fs.pc      = pc;
    assign fs.inst    = inst_rdata;    // stale word when adel, ex covers it
    assign fs.bd      = ds_is_branch;  // decode holds a branch, so this is its slot
    assign fs.ex      = adel;
    assign fs.exccode = adel ? cpu_pkg::EXC_ADEL : cpu_pkg::EXC_NONE;

endmodule

// File: fs_ds_if.sv
`timescale 1ns/1ps

interface fs_ds_if;

    logic               valid;    // fetch holds a live item
    cpu_pkg::word_t     pc;       // pc of the item
    cpu_pkg::word_t     inst;     // word read at pc
    logic               bd;       // item sits in a delay slot
    logic               ex;       // item carries an exception
    cpu_pkg::exc_code_t exccode;  // which one
    logic               allowin;  // decode can take an item this edge

    modport fetch (
        output valid,
        output pc,
        output inst,
        output bd,
        output ex,
        output exccode,
        input  allowin
    );

    modport decode (
        input  valid,
        input  pc,
        input  inst,
        input  bd,
        input  ex,
        input  exccode,
        output allowin
    );

endinterface

// File: cpu_pkg.sv
package cpu_pkg;

    // basic word and field types
    typedef logic [31:0] word_t;      // pc, address, instruction
    typedef logic [4:0]  exc_code_t;  // cp0 cause exccode field
    typedef logic [5:0]  op_t;        // opcode and funct fields

    // exception codes
    localparam exc_code_t EXC_ADEL = 5'd4;     // address error on load or fetch
    localparam exc_code_t EXC_NONE = 5'h1f;    // marks an item with no exception

    // fixed addresses
    localparam word_t RESET_PC        = 32'hbfc0_0000;  // first fetch after reset
    localparam word_t PC_BEFORE_RESET = 32'hbfbf_fffc;  // seq pc lands on RESET_PC
    localparam word_t EXC_VECTOR      = 32'hbfc0_0380;  // general exception entry

    // instruction memory geometry
    localparam int IMEM_AW    = 10;            // word address bits
    localparam int IMEM_DEPTH = 1 << IMEM_AW;  // words in the image

    typedef logic [IMEM_AW-1:0] imem_addr_t;  // word index into the image

    // opcodes seen by the branch decoder
    localparam op_t OP_SPECIAL = 6'h00;  // r-type, look at funct
    localparam op_t OP_J       = 6'h02;
    localparam op_t OP_JAL     = 6'h03;
    localparam op_t OP_BEQ     = 6'h04;
    localparam op_t OP_BNE     = 6'h05;

    // funct codes under OP_SPECIAL
    localparam op_t FUNCT_JR = 6'h08;  // register jump

endpackage
